// File: hdl/avmm_consts.svh
`ifndef AVMM_CONSTS_SVH
`define AVMM_CONSTS_SVH

// Word address width of the on-chip memory (1024 words)
`define AVMM_ADDR_WIDTH 10

// Data word width; byteenable is one bit per byte of this
`define AVMM_DATA_WIDTH 32

// Request FIFO depth inside the memory slave
`define AVMM_FIFO_DEPTH 16

// Distance in cycles between the starts of two refresh windows
`define AVMM_REFRESH_PERIOD 64

// Length of one refresh window in cycles
`define AVMM_REFRESH_CYCLES 6

// Default number of register stages in the slice
`define AVMM_N_REG_STAGES 2

`endif

// File: hdl/avmm_pkg.sv
`include "avmm_consts.svh"

package avmm_pkg;

    // Word address into the memory
    typedef logic [`AVMM_ADDR_WIDTH-1:0] avmm_addr_t;

    // One data word
    typedef logic [`AVMM_DATA_WIDTH-1:0] avmm_data_t;

    // One enable bit per data byte
    typedef logic [`AVMM_DATA_WIDTH/8-1:0] avmm_be_t;

    // Kind of request held in a FIFO entry
    typedef enum logic
    {
        OP_READ,
        OP_WRITE
    } avmm_op_e;

    // Refresh state of the memory slave
    typedef enum logic
    {
        ST_ACTIVE,
        ST_REFRESH
    } avmm_refresh_e;

endpackage

// File: hdl/avmm_req_fifo.sv
`timescale 1ns/100ps

`include "avmm_consts.svh"

// Circular request buffer with a registered almost-full flag
module avmm_req_fifo
    import avmm_pkg::*;
#(
    parameter int DEPTH = `AVMM_FIFO_DEPTH,
    parameter int SKID_SLACK = 1
)
(
    input  logic       mem_slave,
    input  logic       arst_n,
    input  logic       push,
    input  avmm_op_e   push_op,
    input  avmm_addr_t push_address,
    input  avmm_data_t push_writedata,
    input  avmm_be_t   push_byteenable,
    input  logic       pop,
    output avmm_op_e   head_op,
    output avmm_addr_t head_address,
    output avmm_data_t head_writedata,
    output avmm_be_t   head_byteenable,
    output logic       not_empty,
    output logic       almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    avmm_op_e   op_mem [DEPTH];
    avmm_addr_t addr_mem [DEPTH];
    avmm_data_t data_mem [DEPTH];
    avmm_be_t   be_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             do_pop;

    // Popping an empty buffer is ignored
    assign do_pop = pop && not_empty;

    always_comb
    begin
        count_next = count;
        if (push && !do_pop)
            count_next = count + 1'b1;
        else if (!push && do_pop)
            count_next = count - 1'b1;
    end

    always_ff @(posedge mem_slave or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            // Waitrequest toward the slice is asserted while in reset
            almost_full <= 1'b1;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count_next;
            // High once the free slots drop to the slack still needed
            almost_full <= (CNT_W'(DEPTH) - count_next) <= CNT_W'(SKID_SLACK);
        end
    end

    // Entry storage, written at the write pointer on a push
    always_ff @(posedge mem_slave)
    begin
        if (push)
        begin
            op_mem[wr_ptr]   <= push_op;
            addr_mem[wr_ptr] <= push_address;
            data_mem[wr_ptr] <= push_writedata;
            be_mem[wr_ptr]   <= push_byteenable;
        end
    end

    assign head_op         = op_mem[rd_ptr];
    assign head_address    = addr_mem[rd_ptr];
    assign head_writedata  = data_mem[rd_ptr];
    assign head_byteenable = be_mem[rd_ptr];
    assign not_empty       = (count != '0);

endmodule

// File: hdl/avmm_reg_simple.sv
`timescale 1ns/100ps

`include "avmm_consts.svh"

// Register slice for Avalon-MM. The requester sees waitrequest late, so the
// slave behind the slice must treat waitrequest as almost full and keep room
// for every request still travelling through the stages
module avmm_reg_simple
    import avmm_pkg::*;
#(
    parameter int N_REG_STAGES = `AVMM_N_REG_STAGES,
    parameter int N_WAITREQUEST_STAGES = N_REG_STAGES
)
(
    input  logic       mem_slave,
    input  logic       arst_n,
    // Requester side
    input  avmm_addr_t h_address,
    input  logic       h_read,
    input  logic       h_write,
    input  avmm_data_t h_writedata,
    input  avmm_be_t   h_byteenable,
    output logic       h_waitrequest,
    output avmm_data_t h_readdata,
    output logic       h_readdatavalid,
    // Memory side
    output avmm_addr_t m_address,
    output logic       m_read,
    output logic       m_write,
    output avmm_data_t m_writedata,
    output avmm_be_t   m_byteenable,
    input  logic       m_waitrequest,
    input  avmm_data_t m_readdata,
    input  logic       m_readdatavalid
);

    generate
        if (N_REG_STAGES == 0)
        begin : g_wires
            // No stages at all, both directions pass straight through
            assign m_address       = h_address;
            assign m_read          = h_read;
            assign m_write         = h_write;
            assign m_writedata     = h_writedata;
            assign m_byteenable    = h_byteenable;
            assign h_waitrequest   = m_waitrequest;
            assign h_readdata      = m_readdata;
            assign h_readdatavalid = m_readdatavalid;
        end
        else
        begin : g_regs
            // Request control bits, index 1 is nearest the requester
            logic [N_REG_STAGES:1] read_q;
            logic [N_REG_STAGES:1] write_q;
            // Request payload
            avmm_addr_t addr_q [1:N_REG_STAGES];
            avmm_data_t wdata_q [1:N_REG_STAGES];
            avmm_be_t   be_q [1:N_REG_STAGES];
            // Response path, index 1 is nearest the memory
            logic [N_REG_STAGES:1] rvalid_q;
            avmm_data_t rdata_q [1:N_REG_STAGES];

            // A request only enters the pipe when the requester is allowed to
            // issue it, which is when the delayed waitrequest is low
            always_ff @(posedge mem_slave or negedge arst_n)
            begin
                if (!arst_n)
                begin
                    read_q   <= '0;
                    write_q  <= '0;
                    rvalid_q <= '0;
                end
                else
                begin
                    read_q[1]   <= h_read && !h_waitrequest;
                    write_q[1]  <= h_write && !h_waitrequest;
                    rvalid_q[1] <= m_readdatavalid;
                    for (int s = N_REG_STAGES; s > 1; s--)
                    begin
                        read_q[s]   <= read_q[s-1];
                        write_q[s]  <= write_q[s-1];
                        rvalid_q[s] <= rvalid_q[s-1];
                    end
                end
            end

            // Payload moves every cycle; the valid bits above say when it counts
            always_ff @(posedge mem_slave)
            begin
                addr_q[1]  <= h_address;
                wdata_q[1] <= h_writedata;
                be_q[1]    <= h_byteenable;
                rdata_q[1] <= m_readdata;
                for (int s = N_REG_STAGES; s > 1; s--)
                begin
                    addr_q[s]  <= addr_q[s-1];
                    wdata_q[s] <= wdata_q[s-1];
                    be_q[s]    <= be_q[s-1];
                    rdata_q[s] <= rdata_q[s-1];
                end
            end

            // Last request stage drives the memory side
            assign m_address    = addr_q[N_REG_STAGES];
            assign m_read       = read_q[N_REG_STAGES];
            assign m_write      = write_q[N_REG_STAGES];
            assign m_writedata  = wdata_q[N_REG_STAGES];
            assign m_byteenable = be_q[N_REG_STAGES];

            // Last response stage drives the requester side
            assign h_readdata      = rdata_q[N_REG_STAGES];
            assign h_readdatavalid = rvalid_q[N_REG_STAGES];

            if (N_WAITREQUEST_STAGES == 0)
            begin : g_wait_wire
                assign h_waitrequest = m_waitrequest;
            end
            else
            begin : g_wait_regs
                logic [N_WAITREQUEST_STAGES:1] wait_q;

                // Waitrequest has its own shift register and comes out of reset
                // asserted, so nothing is issued before the slave is known
                always_ff @(posedge mem_slave or negedge arst_n)
                begin
                    if (!arst_n)
                    begin
                        wait_q <= '1;
                    end
                    else
                    begin
                        wait_q[1] <= m_waitrequest;
                        for (int w = N_WAITREQUEST_STAGES; w > 1; w--)
                        begin
                            wait_q[w] <= wait_q[w-1];
                        end
                    end
                end

                assign h_waitrequest = wait_q[N_WAITREQUEST_STAGES];
            end
        end
    endgenerate

endmodule

// File: hdl/avmm_mem_slave.sv
`timescale 1ns/100ps

`include "avmm_consts.svh"

// On-chip memory behind the slice. Every request that arrives is queued,
// and waitrequest warns early enough that the queue never overflows
module avmm_mem_slave
    import avmm_pkg::*;
#(
    parameter int SKID_SLACK = 2 * `AVMM_N_REG_STAGES + 1
)
(
    input  logic       mem_slave,
    input  logic       arst_n,
    input  avmm_addr_t address,
    input  logic       read,
    input  logic       write,
    input  avmm_data_t writedata,
    input  avmm_be_t   byteenable,
    output logic       waitrequest,
    output avmm_data_t readdata,
    output logic       readdatavalid
);

    localparam int BE_W  = `AVMM_DATA_WIDTH / 8;
    localparam int WORDS = 1 << `AVMM_ADDR_WIDTH;
    localparam int RCNT_W = $clog2(`AVMM_REFRESH_PERIOD);

    avmm_data_t mem [WORDS];

    logic          push;
    avmm_op_e      push_op;
    logic          pop;
    avmm_op_e      head_op;
    avmm_addr_t    head_address;
    avmm_data_t    head_writedata;
    avmm_be_t      head_byteenable;
    logic          not_empty;
    logic          almost_full;
    avmm_refresh_e state;
    logic [RCNT_W-1:0] refresh_cnt;

    // Requests are taken even while waitrequest is high, since those were
    // already in the slice when the requester saw the warning
    assign push    = read || write;
    assign push_op = write ? OP_WRITE : OP_READ;

    avmm_req_fifo #(
        .DEPTH      (`AVMM_FIFO_DEPTH),
        .SKID_SLACK (SKID_SLACK)
    ) i_req_fifo (
        .mem_slave       (mem_slave),
        .arst_n          (arst_n),
        .push            (push),
        .push_op         (push_op),
        .push_address    (address),
        .push_writedata  (writedata),
        .push_byteenable (byteenable),
        .pop             (pop),
        .head_op         (head_op),
        .head_address    (head_address),
        .head_writedata  (head_writedata),
        .head_byteenable (head_byteenable),
        .not_empty       (not_empty),
        .almost_full     (almost_full)
    );

    assign waitrequest = almost_full;

    // Refresh window occupies the last cycles of every period
    always_ff @(posedge mem_slave or negedge arst_n)
    begin
        if (!arst_n)
        begin
            refresh_cnt <= '0;
            state       <= ST_ACTIVE;
        end
        else
        begin
            if (refresh_cnt == RCNT_W'(`AVMM_REFRESH_PERIOD - 1))
                refresh_cnt <= '0;
            else
                refresh_cnt <= refresh_cnt + 1'b1;

            case (state)
                ST_ACTIVE:
                begin
                    if (refresh_cnt ==
                        RCNT_W'(`AVMM_REFRESH_PERIOD - `AVMM_REFRESH_CYCLES - 1))
                        state <= ST_REFRESH;
                end
                ST_REFRESH:
                begin
                    // Back to work as the counter wraps
                    if (refresh_cnt == RCNT_W'(`AVMM_REFRESH_PERIOD - 1))
                        state <= ST_ACTIVE;
                end
                default:
                    state <= ST_ACTIVE;
            endcase
        end
    end

    // Nothing leaves the queue during refresh
    assign pop = not_empty && (state == ST_ACTIVE);

    // Write only the enabled bytes; a read captures the whole word
    always_ff @(posedge mem_slave)
    begin
        if (pop && head_op == OP_WRITE)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (head_byteenable[b])
                    mem[head_address][8*b +: 8] <= head_writedata[8*b +: 8];
            end
        end
        if (pop && head_op == OP_READ)
            readdata <= mem[head_address];
    end

    // Responses leave in pop order, which is request order
    always_ff @(posedge mem_slave or negedge arst_n)
    begin
        if (!arst_n)
            readdatavalid <= 1'b0;
        else
            readdatavalid <= pop && (head_op == OP_READ);
    end

endmodule

// File: hdl/avmm_reg_pipe_top.sv
`timescale 1ns/100ps

`include "avmm_consts.svh"

// Requester-facing register slice in front of the memory slave
module avmm_reg_pipe_top
    import avmm_pkg::*;
#(
    parameter int N_REG_STAGES = `AVMM_N_REG_STAGES
)
(
    input  logic       mem_slave,
    input  logic       arst_n,
    input  avmm_addr_t address,
    input  logic       read,
    input  logic       write,
    input  avmm_data_t writedata,
    input  avmm_be_t   byteenable,
    output logic       waitrequest,
    output avmm_data_t readdata,
    output logic       readdatavalid
);

    // Waitrequest is delayed as much as the request path
    localparam int N_WAITREQUEST_STAGES = N_REG_STAGES;
    // Room for requests in the stages, in the waitrequest delay, plus one for
    // the registered almost-full flag
    localparam int SKID_SLACK = N_REG_STAGES + N_WAITREQUEST_STAGES + 1;

    avmm_addr_t m_address;
    logic       m_read;
    logic       m_write;
    avmm_data_t m_writedata;
    avmm_be_t   m_byteenable;
    logic       m_waitrequest;
    avmm_data_t m_readdata;
    logic       m_readdatavalid;

    avmm_reg_simple #(
        .N_REG_STAGES         (N_REG_STAGES),
        .N_WAITREQUEST_STAGES (N_WAITREQUEST_STAGES)
    ) i_avmm_reg_simple (
        .mem_slave       (mem_slave),
        .arst_n          (arst_n),
        .h_address       (address),
        .h_read          (read),
        .h_write         (write),
        .h_writedata     (writedata),
        .h_byteenable    (byteenable),
        .h_waitrequest   (waitrequest),
        .h_readdata      (readdata),
        .h_readdatavalid (readdatavalid),
        .m_address       (m_address),
        .m_read          (m_read),
        .m_write         (m_write),
        .m_writedata     (m_writedata),
        .m_byteenable    (m_byteenable),
        .m_waitrequest   (m_waitrequest),
        .m_readdata      (m_readdata),
        .m_readdatavalid (m_readdatavalid)
    );

    avmm_mem_slave #(
        .SKID_SLACK (SKID_SLACK)
    ) i_avmm_mem_slave (
        .mem_slave     (mem_slave),
        .arst_n        (arst_n),
        .address       (m_address),
        .read          (m_read),
        .write         (m_write),
        .writedata     (m_writedata),
        .byteenable    (m_byteenable),
        .waitrequest   (m_waitrequest),
        .readdata      (m_readdata),
        .readdatavalid (m_readdatavalid)
    );

endmodule

// File: tb/avmm_reg_props.sv
`timescale 1ns/100ps

`include "avmm_consts.svh"

// Protocol checks for one Avalon-MM port. The same module is bound to the top
// (requester side) and to the memory slave (FIFO side)
module avmm_reg_props
    import avmm_pkg::*;
(
    input logic       mem_slave,
    input logic       arst_n,
    input logic       req_valid,
    input logic       req_wait,
    input avmm_addr_t req_address,
    input logic       push,
    input logic       pop,
    input logic       readdatavalid
);

    // Occupancy rebuilt from push and pop, since pop is already gated by not_empty
    int unsigned level;

    // Failure tallies, one per assertion
    int fail_overflow = 0;
    int fail_valid = 0;
    int fail_hold = 0;

    always_ff @(posedge mem_slave or negedge arst_n)
    begin
        if (!arst_n)
            level <= 0;
        else if (push && !pop)
            level <= level + 1;
        else if (!push && pop)
            level <= level - 1;
    end

    // The FIFO slack must absorb every request still in the slice
    a_no_overflow: assert property (@(posedge mem_slave) disable iff (!arst_n)
        (level == `AVMM_FIFO_DEPTH) |-> !push)
    else
    begin
        $error("request pushed into a full FIFO");
        fail_overflow++;
    end

    // No response may be signalled while reset is applied
    a_no_valid_in_reset: assert property (@(posedge mem_slave) !arst_n |-> !readdatavalid)
    else
    begin
        $error("readdatavalid high during reset");
        fail_valid++;
    end

    // A request that saw waitrequest must be presented again unchanged
    a_hold_address: assert property (@(posedge mem_slave) disable iff (!arst_n)
        (req_valid && req_wait) |=> (req_valid && $stable(req_address)))
    else
    begin
        $error("request address changed while waitrequest was high");
        fail_hold++;
    end

endmodule

// Requester side of the top; there is no FIFO here
bind avmm_reg_pipe_top avmm_reg_props i_props (
    .mem_slave     (mem_slave),
    .arst_n        (arst_n),
    .req_valid     (read || write),
    .req_wait      (waitrequest),
    .req_address   (address),
    .push          (1'b0),
    .pop           (1'b0),
    .readdatavalid (readdatavalid)
);

// Slave side, where in-flight requests legally arrive during waitrequest
bind avmm_mem_slave avmm_reg_props i_props (
    .mem_slave     (mem_slave),
    .arst_n        (arst_n),
    .req_valid     (1'b0),
    .req_wait      (waitrequest),
    .req_address   (address),
    .push          (push),
    .pop           (pop),
    .readdatavalid (readdatavalid)
);

// File: tb/tb_avmm_reg_pipe.sv
`timescale 1ns/100ps

`include "avmm_consts.svh"

// Directed testbench for the register slice in front of the memory slave
module tb_avmm_reg_pipe
    import avmm_pkg::*;
();

    localparam int N_WRITE_READ = 16;
    localparam int N_BE_PATTERNS = 4;
    localparam int N_STREAM = 200;
    localparam int N_RANDOM_WORDS = 64;
    localparam int N_RANDOM = 300;
    localparam int TOTAL_REQUESTS = 2 * N_WRITE_READ + 1 + 2 * N_BE_PATTERNS
                                  + N_STREAM + N_RANDOM_WORDS + N_RANDOM;
    // Eight cycles per request is generous even with refresh stalls
    localparam int TIMEOUT_CYCLES = TOTAL_REQUESTS * 8 + 500;
    localparam logic [15:0] LFSR_SEED = 16'd51736;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic       mem_slave = 1'b0;
    logic       arst_n;
    avmm_addr_t address;
    logic       read;
    logic       write;
    avmm_data_t writedata;
    avmm_be_t   byteenable;
    logic       waitrequest;
    avmm_data_t readdata;
    logic       readdatavalid;

    // Reference memory and the reads still waiting for data
    avmm_data_t ref_mem [1 << `AVMM_ADDR_WIDTH];
    avmm_data_t exp_q [$];

    int mismatch_count = 0;
    int other_count = 0;
    int cycle_count = 0;
    logic [15:0] lfsr_state;

    avmm_reg_pipe_top i_avmm_reg_pipe_top (
        .mem_slave     (mem_slave),
        .arst_n        (arst_n),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

    always #50 mem_slave = ~mem_slave;

    // Watchdog on the whole run
    always @(posedge mem_slave)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, responses stopped arriving", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_data(input string name, input avmm_data_t exp, input avmm_data_t act);
        if (act !== exp)
        begin
            mismatch_count++;
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            mismatch_count++;
            $display("MISMATCH time=%0t signal=%s expected=%b actual=%b",
                     $time, name, exp, act);
        end
    endtask

    // Responses are sampled mid-cycle, away from the clock edge
    always @(negedge mem_slave)
    begin
        if (arst_n && readdatavalid)
        begin
            if (exp_q.size() == 0)
            begin
                other_count++;
                $display("Read response at %0t arrived with no read outstanding", $time);
            end
            else
            begin
                check_data("readdata", exp_q.pop_front(), readdata);
            end
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        return s >> 1;
    endfunction

    // One LFSR step per bit handed out
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Only the enabled bytes of the stored word change
    task automatic model_write(input avmm_addr_t a, input avmm_data_t d, input avmm_be_t be);
        for (int b = 0; b < `AVMM_DATA_WIDTH / 8; b++)
        begin
            if (be[b])
                ref_mem[a][8*b +: 8] = d[8*b +: 8];
        end
    endtask

    // Entered at a rising edge, returns at the edge that took the request
    task automatic issue_request(input avmm_op_e op, input avmm_addr_t a,
                                 input avmm_data_t d, input avmm_be_t be);
        read       <= (op == OP_READ);
        write      <= (op == OP_WRITE);
        address    <= a;
        writedata  <= d;
        byteenable <= be;
        @(negedge mem_slave);
        while (waitrequest)
            @(negedge mem_slave);
        @(posedge mem_slave);
        // Accepted here, so the model follows in acceptance order
        if (op == OP_WRITE)
            model_write(a, d, be);
        else
            exp_q.push_back(ref_mem[a]);
    endtask

    task automatic go_idle();
        read  <= 1'b0;
        write <= 1'b0;
    endtask

    task automatic wait_responses();
        while (exp_q.size() != 0)
            @(negedge mem_slave);
        @(posedge mem_slave);
    endtask

    task automatic test_reset();
        @(negedge mem_slave);
        check_bit("waitrequest", 1'b1, waitrequest);
        check_bit("readdatavalid", 1'b0, readdatavalid);
        check_bit("m_waitrequest", 1'b1, i_avmm_reg_pipe_top.m_waitrequest);
        check_bit("m_read", 1'b0, i_avmm_reg_pipe_top.m_read);
        check_bit("m_write", 1'b0, i_avmm_reg_pipe_top.m_write);
        @(posedge mem_slave);
        arst_n <= 1'b1;
        // Waitrequest pipe still holds its reset ones one cycle later
        @(negedge mem_slave);
        check_bit("waitrequest", 1'b1, waitrequest);
        check_bit("readdatavalid", 1'b0, readdatavalid);
        @(posedge mem_slave);
    endtask

    task automatic test_write_read();
        for (int i = 0; i < N_WRITE_READ; i++)
            issue_request(OP_WRITE, avmm_addr_t'(i), avmm_data_t'(32'h0101_0101 * (i + 1)), '1);
        for (int i = 0; i < N_WRITE_READ; i++)
            issue_request(OP_READ, avmm_addr_t'(i), '0, '1);
        go_idle();
        wait_responses();
    endtask

    task automatic test_byte_enable();
        avmm_be_t   patterns [N_BE_PATTERNS] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        avmm_addr_t a;
        a = avmm_addr_t'(100);
        issue_request(OP_WRITE, a, 32'h1122_3344, '1);
        for (int p = 0; p < N_BE_PATTERNS; p++)
        begin
            issue_request(OP_WRITE, a, avmm_data_t'(32'hA0B0_C0D0 + p), patterns[p]);
            issue_request(OP_READ, a, '0, '0);
        end
        go_idle();
        wait_responses();
    endtask

    task automatic test_stream_backpressure();
        // Reads go out back to back and are held whenever waitrequest is high
        for (int i = 0; i < N_STREAM; i++)
            issue_request(OP_READ, avmm_addr_t'(i % N_WRITE_READ), '0, '1);
        go_idle();
        wait_responses();
    endtask

    task automatic test_random_mix();
        logic [31:0] op_bit;
        logic [31:0] a_bits;
        logic [31:0] d_bits;
        logic [31:0] be_bits;
        // Give every word in the random range a known value first
        for (int i = 0; i < N_RANDOM_WORDS; i++)
        begin
            take_bits(32, d_bits);
            issue_request(OP_WRITE, avmm_addr_t'(i), d_bits, '1);
        end
        for (int i = 0; i < N_RANDOM; i++)
        begin
            take_bits(1, op_bit);
            take_bits(6, a_bits);
            take_bits(32, d_bits);
            take_bits(4, be_bits);
            if (op_bit[0])
            begin
                issue_request(OP_WRITE, avmm_addr_t'(a_bits[5:0]), d_bits, be_bits[3:0]);
            end
            else
            begin
                issue_request(OP_READ, avmm_addr_t'(a_bits[5:0]), '0, '1);
            end
        end
        go_idle();
        wait_responses();
    endtask

    // Failures seen by the bound assertion modules
    function automatic int assert_failures();
        return i_avmm_reg_pipe_top.i_props.fail_overflow
             + i_avmm_reg_pipe_top.i_props.fail_valid
             + i_avmm_reg_pipe_top.i_props.fail_hold
             + i_avmm_reg_pipe_top.i_avmm_mem_slave.i_props.fail_overflow
             + i_avmm_reg_pipe_top.i_avmm_mem_slave.i_props.fail_valid
             + i_avmm_reg_pipe_top.i_avmm_mem_slave.i_props.fail_hold;
    endfunction

    initial
    begin
        arst_n     = 1'b0;
        read       = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        byteenable = '0;
        lfsr_state = LFSR_SEED;

        test_reset();
        test_write_read();
        test_byte_enable();
        test_stream_backpressure();
        test_random_mix();

        // A few idle cycles catch any stray response
        repeat (4) @(posedge mem_slave);
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, other_count, assert_failures());
        if (mismatch_count + other_count + assert_failures() == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: compile.f
+incdir+hdl
hdl/avmm_pkg.sv
hdl/avmm_req_fifo.sv
hdl/avmm_reg_simple.sv
hdl/avmm_mem_slave.sv
hdl/avmm_reg_pipe_top.sv
tb/avmm_reg_props.sv
tb/tb_avmm_reg_pipe.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_avmm_reg_pipe -f compile.f -o sim_avmm \
    && ./obj_dir/sim_avmm | tee /dev/stderr | grep "Finished with no errors" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
